// File: Makefile
# Verilator build and run for the SPI register block testbench

VERILATOR  := verilator
TOP        := tb_spi_reg_top
FILELIST   := filelist.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(BUILD_DIR)
RUN_FLAGS  := +verilator+error+limit+1000
PASS_MSG   := RESULT: PASS
SIM        := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: compile
	@out="$$($(SIM) $(RUN_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: filelist.f
+incdir+verilog
verilog/spi_frame_pkg.sv
verilog/wb_reg_pkg.sv
verilog/wb_if.sv
verilog/spi_slave.sv
verilog/spi_cmd_bridge.sv
verilog/spi_reg_bank.sv
verilog/spi_reg_top.sv
testbench/spi_reg_assertions.sv
testbench/spi_reg_checker.sv
testbench/tb_spi_reg_top.sv

// File: testbench/spi_reg_assertions.sv
module spi_reg_assertions (
    input logic clk,
    input logic rst,
    input logic cyc,
    input logic stb,
    input logic ack,
    input logic rx_valid
);

    int unsigned fail_count = 0;

    // ack only inside an open bus cycle
    ack_in_cycle: assert property (@(posedge clk) disable iff (rst) ack |-> (cyc && stb))
        else begin
            fail_count++;
            $error("ack seen while cyc or stb is low");
        end

    // frame strobe is a single cycle
    rx_valid_pulse: assert property (@(posedge clk) disable iff (rst) rx_valid |=> !rx_valid)
        else begin
            fail_count++;
            $error("rx_valid held high for two cycles");
        end

    cyc_in_reset: assert property (@(posedge clk) rst |-> !cyc)
        else begin
            fail_count++;
            $error("cyc high during reset");
        end

endmodule

// File: testbench/spi_reg_checker.sv
`include "spi_params.svh"

module spi_reg_checker (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     frame_done,
    input  spi_frame_pkg::spi_word_t sent_word,
    input  spi_frame_pkg::spi_word_t ret_word,
    input  int                       bit_count,
    input  wb_reg_pkg::reg_data_t    ctrl_out,
    output int                       error_count
);
    import spi_frame_pkg::*;
    import wb_reg_pkg::*;

    reg_data_t model_regs [1 << `REG_ADDR_BITS];
    spi_word_t last_resp;
    int        frame_num;
    int        errors;

    assign error_count = errors;

    task automatic check_frame();
        logic      cmd_we;
        reg_addr_t cmd_adr;
        reg_data_t cmd_dat;
        spi_word_t exp_word;
        cmd_we  = sent_word[`SPI_FRAME_BITS-1];
        cmd_adr = sent_word[`REG_DATA_BITS +: `REG_ADDR_BITS];
        cmd_dat = sent_word[`REG_DATA_BITS-1:0];
        // cut frame only carries the leading bits of the response
        if (bit_count < `SPI_FRAME_BITS) begin
            exp_word = last_resp >> (`SPI_FRAME_BITS - bit_count);
        end else begin
            exp_word = last_resp;
        end
        if (ret_word !== exp_word) begin
            errors++;
            $display("Error: miso expected 0x%03h actual 0x%03h in frame %0d",
                     exp_word, ret_word, frame_num);
        end
        if (bit_count == `SPI_FRAME_BITS) begin
            if (cmd_we) begin
                model_regs[cmd_adr] = cmd_dat;
            end
            last_resp = {cmd_we, cmd_adr, model_regs[cmd_adr]};
        end
        if (ctrl_out !== model_regs[0]) begin
            errors++;
            $display("Error: ctrl_out expected 0x%02h actual 0x%02h after frame %0d",
                     model_regs[0], ctrl_out, frame_num);
        end
        frame_num++;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < (1 << `REG_ADDR_BITS); i++) begin
                model_regs[i] = '0;
            end
            last_resp = '0;
            frame_num = 0;
            errors    = 0;
        end else if (frame_done) begin
            check_frame();
        end
    end

endmodule

// File: testbench/tb_spi_reg_top.sv
`include "spi_params.svh"

module tb_spi_reg_top;
    import spi_frame_pkg::*;
    import wb_reg_pkg::*;

    localparam int SEED           = 89;
    localparam int RESET_CYCLES   = 8;
    localparam int RANDOM_FRAMES  = 200;
    localparam int SCLK_HALF      = 6;
    localparam int CS_LEAD        = 4;
    // at most about 180 cycles per frame, 213 frames
    localparam int TIMEOUT_CYCLES = 40000;

    logic        clk = 1'b0;
    logic        rst;
    logic        sclk;
    logic        cs;
    logic        mosi;
    logic        miso;
    reg_data_t   ctrl_out;

    logic        frame_done;
    spi_word_t   sent_word;
    spi_word_t   ret_word;
    int          bit_count;
    int          value_errors;
    int          timeout_errors = 0;
    int          cycle_count = 0;
    int unsigned seed_init;

    always #20 clk = ~clk;

    spi_reg_top spi_reg_top_i (
        .clk      (clk),
        .rst      (rst),
        .sclk     (sclk),
        .cs       (cs),
        .mosi     (mosi),
        .miso     (miso),
        .ctrl_out (ctrl_out)
    );

    spi_reg_checker spi_reg_checker_i (
        .clk         (clk),
        .rst         (rst),
        .frame_done  (frame_done),
        .sent_word   (sent_word),
        .ret_word    (ret_word),
        .bit_count   (bit_count),
        .ctrl_out    (ctrl_out),
        .error_count (value_errors)
    );

    bind spi_reg_top spi_reg_assertions spi_reg_assertions_i (
        .clk      (clk),
        .rst      (rst),
        .cyc      (wb_bus.cyc),
        .stb      (wb_bus.stb),
        .ack      (wb_bus.ack),
        .rx_valid (rx_valid)
    );

    // mode 1 master, mosi set on rising sclk, miso taken on falling sclk
    task automatic shift_frame(input spi_word_t word, input int nbits,
                               output spi_word_t returned);
        returned = '0;
        cs       = 1'b0;
        sclk     = 1'b0;
        repeat (CS_LEAD) @(negedge clk);
        for (int i = 0; i < nbits; i++) begin
            sclk = 1'b1;
            mosi = word[`SPI_FRAME_BITS-1-i];
            repeat (SCLK_HALF) @(negedge clk);
            sclk     = 1'b0;
            returned = {returned[`SPI_FRAME_BITS-2:0], miso};
            repeat (SCLK_HALF) @(negedge clk);
        end
        cs   = 1'b1;
        mosi = 1'b0;
    endtask

    task automatic run_frame(input spi_word_t word, input int nbits);
        spi_word_t returned;
        int        gap;
        shift_frame(word, nbits, returned);
        gap = 10 + int'($urandom % 11);
        repeat (gap) @(negedge clk);
        sent_word  = word;
        ret_word   = returned;
        bit_count  = nbits;
        frame_done = 1'b1;
        @(negedge clk);
        frame_done = 1'b0;
    endtask

    task automatic finish_run();
        int assert_errors;
        assert_errors = int'(spi_reg_top_i.spi_reg_assertions_i.fail_count);
        $display("errors: value %0d, assertion %0d, timeout %0d",
                 value_errors, assert_errors, timeout_errors);
        if (value_errors == 0 && assert_errors == 0 && timeout_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            timeout_errors++;
            $display("timeout: run did not complete within %0d clock cycles", TIMEOUT_CYCLES);
            finish_run();
        end
    end

    initial begin
        logic      we;
        reg_addr_t addr;
        reg_data_t data;
        int        nbits;
        rst        = 1'b1;
        cs         = 1'b1;
        sclk       = 1'b0;
        mosi       = 1'b0;
        frame_done = 1'b0;
        sent_word  = '0;
        ret_word   = '0;
        bit_count  = 0;
        seed_init  = $urandom(SEED);
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        repeat (4) @(negedge clk);

        // every register reads zero after reset
        for (int a = 0; a < (1 << `REG_ADDR_BITS); a++) begin
            run_frame({1'b0, reg_addr_t'(a), reg_data_t'(0)}, `SPI_FRAME_BITS);
        end

        // write and read back, register 0 first
        for (int k = 0; k < 2; k++) begin
            addr = (k == 0) ? reg_addr_t'(0) : reg_addr_t'($urandom);
            data = reg_data_t'($urandom);
            run_frame({1'b1, addr, data}, `SPI_FRAME_BITS);
            run_frame({1'b0, addr, reg_data_t'(0)}, `SPI_FRAME_BITS);
        end

        for (int n = 0; n < RANDOM_FRAMES; n++) begin
            we    = 1'($urandom);
            addr  = reg_addr_t'($urandom);
            data  = reg_data_t'($urandom);
            nbits = `SPI_FRAME_BITS;
            if ($urandom % 10 == 0) begin
                nbits = 1 + int'($urandom % 11);
            end
            run_frame({we, addr, data}, nbits);
        end

        // collects the response of the last random frame
        run_frame({1'b0, reg_addr_t'(0), reg_data_t'(0)}, `SPI_FRAME_BITS);
        finish_run();
    end

endmodule

// File: verilog/spi_cmd_bridge.sv
`include "spi_params.svh"

module spi_cmd_bridge (
    input  logic                     clk,
    input  logic                     rst,
    input  spi_frame_pkg::spi_word_t rx_word,
    input  logic                     rx_valid,
    output spi_frame_pkg::spi_word_t tx_word,
    wb_if.master                     wb
);
    import wb_reg_pkg::*;

    bridge_state_t state;
    logic          cmd_we;
    reg_addr_t     cmd_adr;
    reg_data_t     cmd_dat;
    reg_data_t     resp_dat;

    // split the frame into its fields
    always_ff @(posedge clk) begin
        if (rx_valid && state == br_idle) begin
            cmd_we  <= rx_word[`SPI_FRAME_BITS-1];
            cmd_adr <= rx_word[`REG_DATA_BITS +: `REG_ADDR_BITS];
            cmd_dat <= rx_word[`REG_DATA_BITS-1:0];
        end
    end

    // a write answers with the data it wrote
    assign resp_dat = cmd_we ? cmd_dat : wb.dat_r;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= br_idle;
            tx_word <= '0;
        end else begin
            case (state)
                br_idle: begin
                    if (rx_valid) begin
                        state <= br_bus;
                    end
                end
                br_bus: begin
                    if (wb.ack) begin
                        state   <= br_done;
                        tx_word <= {cmd_we, cmd_adr, resp_dat};
                    end
                end
                br_done: state <= br_idle;
                default: state <= br_idle;
            endcase
        end
    end

    // bus request lasts for the whole br_bus state
    assign wb.cyc   = (state == br_bus);
    assign wb.stb   = (state == br_bus);
    assign wb.we    = cmd_we;
    assign wb.adr   = cmd_adr;
    assign wb.dat_w = cmd_dat;

endmodule

// File: verilog/spi_frame_pkg.sv
`include "spi_params.svh"

package spi_frame_pkg;

    // command frame, also the response word
    typedef logic [`SPI_FRAME_BITS-1:0] spi_word_t;

    // counts 0 .. frame length
    typedef logic [$clog2(`SPI_FRAME_BITS + 1)-1:0] spi_bit_idx_t;

    typedef enum logic {
        rx_idle,
        rx_shift
    } spi_rx_state_t;

    typedef enum logic {
        tx_idle,
        tx_shift
    } spi_tx_state_t;

endpackage

// File: verilog/spi_params.svh
`ifndef SPI_PARAMS_SVH
`define SPI_PARAMS_SVH

// one command frame: write flag, address, data
`define SPI_FRAME_BITS 12

// register bank geometry
`define REG_ADDR_BITS 3
`define REG_DATA_BITS 8

`endif

// File: verilog/spi_reg_bank.sv
`include "spi_params.svh"

module spi_reg_bank (
    input  logic                  clk,
    input  logic                  rst,
    wb_if.slave                   wb,
    output wb_reg_pkg::reg_data_t ctrl_out
);
    import wb_reg_pkg::*;

    reg_data_t regs [1 << `REG_ADDR_BITS];
    logic      ack_q;
    logic      req;

    // new request, not yet acknowledged
    assign req = wb.cyc & wb.stb & ~ack_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack_q <= 1'b0;
            for (int i = 0; i < (1 << `REG_ADDR_BITS); i++) begin
                regs[i] <= '0;
            end
        end else begin
            ack_q <= req;
            // write lands on the edge where ack rises
            if (req && wb.we) begin
                regs[wb.adr] <= wb.dat_w;
            end
        end
    end

    assign wb.ack   = ack_q;
    assign wb.dat_r = regs[wb.adr];

    // register 0 drives the control port
    assign ctrl_out = regs[0];

endmodule

// File: verilog/spi_reg_top.sv
`include "spi_params.svh"

module spi_reg_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      sclk,
    input  logic                      cs,
    input  logic                      mosi,
    output logic                      miso,
    output logic [`REG_DATA_BITS-1:0] ctrl_out
);
    import spi_frame_pkg::*;

    spi_word_t rx_word;
    spi_word_t tx_word;
    logic      rx_valid;

    wb_if wb_bus ();

    spi_slave spi_slave_i (
        .clk      (clk),
        .rst      (rst),
        .sclk     (sclk),
        .cs       (cs),
        .mosi     (mosi),
        .miso     (miso),
        .tx_word  (tx_word),
        .rx_word  (rx_word),
        .rx_valid (rx_valid)
    );

    spi_cmd_bridge spi_cmd_bridge_i (
        .clk      (clk),
        .rst      (rst),
        .rx_word  (rx_word),
        .rx_valid (rx_valid),
        .tx_word  (tx_word),
        .wb       (wb_bus.master)
    );

    spi_reg_bank spi_reg_bank_i (
        .clk      (clk),
        .rst      (rst),
        .wb       (wb_bus.slave),
        .ctrl_out (ctrl_out)
    );

endmodule

// File: verilog/spi_slave.sv
`include "spi_params.svh"

module spi_slave (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     sclk,
    input  logic                     cs,
    input  logic                     mosi,
    output logic                     miso,
    input  spi_frame_pkg::spi_word_t tx_word,
    output spi_frame_pkg::spi_word_t rx_word,
    output logic                     rx_valid
);
    import spi_frame_pkg::*;

    logic [1:0]    sclk_sync;
    logic [1:0]    cs_sync;
    logic [1:0]    mosi_sync;
    logic          sclk_prev;
    logic          sclk_rise;
    logic          sclk_fall;
    logic          cs_q;
    logic          mosi_q;

    spi_rx_state_t rx_state;
    spi_bit_idx_t  rx_cnt;
    spi_word_t     rx_shreg;
    logic          rx_take;
    logic          rx_last;

    spi_tx_state_t tx_state;
    spi_bit_idx_t  tx_cnt;
    spi_word_t     tx_shreg;
    logic          tx_done;

    // two flops per pin, then sclk history for edges
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sclk_sync <= '0;
            cs_sync   <= '1;
            mosi_sync <= '0;
            sclk_prev <= 1'b0;
        end else begin
            sclk_sync <= {sclk_sync[0], sclk};
            cs_sync   <= {cs_sync[0], cs};
            mosi_sync <= {mosi_sync[0], mosi};
            sclk_prev <= sclk_sync[1];
        end
    end

    assign sclk_rise = sclk_sync[1] & ~sclk_prev;
    assign sclk_fall = ~sclk_sync[1] & sclk_prev;
    assign cs_q      = cs_sync[1];
    assign mosi_q    = mosi_sync[1];

    assign rx_take = (rx_state == rx_shift) && !cs_q && sclk_fall;
    assign rx_last = (rx_cnt == spi_bit_idx_t'(`SPI_FRAME_BITS - 1));
    assign tx_done = (tx_cnt == spi_bit_idx_t'(`SPI_FRAME_BITS));

    // receive side, mosi sampled on falling sclk
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_state <= rx_idle;
            rx_cnt   <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (rx_state)
                rx_idle: begin
                    rx_cnt <= '0;
                    if (!cs_q) begin
                        rx_state <= rx_shift;
                    end
                end
                rx_shift: begin
                    if (cs_q) begin
                        // partial word is dropped
                        rx_state <= rx_idle;
                    end else if (sclk_fall) begin
                        rx_cnt <= rx_cnt + 1'b1;
                        if (rx_last) begin
                            rx_valid <= 1'b1;
                            rx_state <= rx_idle;
                        end
                    end
                end
                default: rx_state <= rx_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rx_take) begin
            rx_shreg <= {rx_shreg[`SPI_FRAME_BITS-2:0], mosi_q};
            if (rx_last) begin
                rx_word <= {rx_shreg[`SPI_FRAME_BITS-2:0], mosi_q};
            end
        end
    end

    // transmit side, miso changes on rising sclk
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tx_state <= tx_idle;
            tx_cnt   <= '0;
            miso     <= 1'b0;
        end else begin
            case (tx_state)
                tx_idle: begin
                    tx_cnt <= '0;
                    miso   <= 1'b0;
                    if (!cs_q) begin
                        tx_state <= tx_shift;
                    end
                end
                tx_shift: begin
                    if (cs_q) begin
                        tx_state <= tx_idle;
                        miso     <= 1'b0;
                    end else if (sclk_rise) begin
                        if (tx_done) begin
                            miso <= 1'b0;
                        end else begin
                            miso   <= tx_shreg[`SPI_FRAME_BITS-1];
                            tx_cnt <= tx_cnt + 1'b1;
                        end
                    end
                end
                default: tx_state <= tx_idle;
            endcase
        end
    end

    // response latched as cs goes low
    always_ff @(posedge clk) begin
        if (tx_state == tx_idle && !cs_q) begin
            tx_shreg <= tx_word;
        end else if (tx_state == tx_shift && !cs_q && sclk_rise && !tx_done) begin
            tx_shreg <= {tx_shreg[`SPI_FRAME_BITS-2:0], 1'b0};
        end
    end

endmodule

// File: verilog/wb_if.sv
interface wb_if;
    import wb_reg_pkg::*;

    logic      cyc;
    logic      stb;
    logic      we;
    reg_addr_t adr;
    reg_data_t dat_w;
    reg_data_t dat_r;
    logic      ack;

    modport master (
        output cyc, stb, we, adr, dat_w,
        input  dat_r, ack
    );

    modport slave (
        input  cyc, stb, we, adr, dat_w,
        output dat_r, ack
    );

endinterface

// File: verilog/wb_reg_pkg.sv
`include "spi_params.svh"

package wb_reg_pkg;

    typedef logic [`REG_ADDR_BITS-1:0] reg_addr_t;
    typedef logic [`REG_DATA_BITS-1:0] reg_data_t;

    // one bus cycle per command
    typedef enum logic [1:0] {
        br_idle,
        br_bus,
        br_done
    } bridge_state_t;

endpackage
